//--- rtl/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

	// instruction field bit positions
	localparam int OPC_LSB = 0;
	localparam int OPC_MSB = 6;
	localparam int RD_LSB  = 7;
	localparam int RD_MSB  = 11;
	localparam int F3_LSB  = 12;
	localparam int F3_MSB  = 14;
	localparam int RS1_LSB = 15;
	localparam int RS1_MSB = 19;
	localparam int RS2_LSB = 20;
	localparam int RS2_MSB = 24;
	localparam int F7_LSB  = 25;
	localparam int F7_MSB  = 31;

	// major opcodes of the supported subset
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;

	// funct3, alu group and word access
	localparam logic [2:0] F3_ADD  = 3'b000;
	localparam logic [2:0] F3_XOR  = 3'b100;
	localparam logic [2:0] F3_OR   = 3'b110;
	localparam logic [2:0] F3_AND  = 3'b111;
	localparam logic [2:0] F3_WORD = 3'b010;

	// funct7, sub is the only alternate encoding kept
	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_SUB  = 7'b0100000;

	// alu operations, pass-b serves lui
	typedef enum logic [2:0] {
		ALU_ADD    = 3'd0,
		ALU_SUB    = 3'd1,
		ALU_AND    = 3'd2,
		ALU_OR     = 3'd3,
		ALU_XOR    = 3'd4,
		ALU_PASS_B = 3'd5
	} alu_op_e;

endpackage

`default_nettype wire

//--- rtl/core_pipe_pkg.sv
`default_nettype none

package core_pipe_pkg;

	import rv_isa_pkg::*;

	// one machine word
	typedef logic [31:0] xlen_t;

	// register index
	typedef logic [4:0] reg_idx_t;

	// fetch to decode
	typedef struct packed {
		xlen_t pc;
		xlen_t instr;
	} fetch_pkt_t;

	// decode to execute, operands already resolved
	typedef struct packed {
		alu_op_e  alu_op;
		xlen_t    op_a;
		xlen_t    op_b;
		reg_idx_t rd;
		logic     wen;
		logic     is_load;
		logic     is_store;
		xlen_t    store_data;
	} issue_pkt_t;

	// execute to lsu
	// result doubles as the memory address
	typedef struct packed {
		xlen_t    result;
		reg_idx_t rd;
		logic     wen;
		logic     is_load;
		logic     is_store;
		xlen_t    store_data;
	} mem_pkt_t;

endpackage

`default_nettype wire

//--- rtl/bypass_if.sv
`timescale 1ns/10ps
`default_nettype none

interface bypass_if import core_pipe_pkg::*; ();

	// execute stage view
	logic     ex_valid;
	logic     ex_wen;
	reg_idx_t ex_rd;
	xlen_t    ex_result;
	logic     ex_is_load;

	// lsu stage view
	// ls_data_ok low means a load still waits for its response
	logic     ls_valid;
	logic     ls_wen;
	reg_idx_t ls_rd;
	xlen_t    ls_data;
	logic     ls_data_ok;

	modport ex_src (output ex_valid, ex_wen, ex_rd, ex_result, ex_is_load);

	modport ls_src (output ls_valid, ls_wen, ls_rd, ls_data, ls_data_ok);

	modport sink (
		input ex_valid, ex_wen, ex_rd, ex_result, ex_is_load,
		input ls_valid, ls_wen, ls_rd, ls_data, ls_data_ok
	);

endinterface

`default_nettype wire

//--- rtl/stage_reg.sv
`timescale 1ns/10ps
`default_nettype none

module stage_reg #(
	parameter type PAYLOAD_T = logic [31:0]
) (
	input  wire      clock,
	input  wire      rst_n_i,
	input  wire      in_valid_i,
	output logic     in_allowin_o,
	input  PAYLOAD_T in_pkt_i,
	output logic     out_valid_o,
	input  wire      out_allowin_i,
	output PAYLOAD_T out_pkt_o
);

	logic     valid_q;
	PAYLOAD_T pkt_q;

	// accept when empty or being drained this cycle
	assign in_allowin_o = !valid_q || out_allowin_i;
	assign out_valid_o  = valid_q;
	assign out_pkt_o    = pkt_q;

	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			valid_q <= 1'b0;
		end else if (in_allowin_o) begin
			valid_q <= in_valid_i;
		end
	end

	// payload follows the handshake only
	always_ff @(posedge clock) begin
		if (in_valid_i && in_allowin_o) begin
			pkt_q <= in_pkt_i;
		end
	end

	// upstream keeps an offered entry until it is taken
	a_hold_stable: assert property (@(posedge clock) disable iff (!rst_n_i)
		in_valid_i && !in_allowin_o |=> in_valid_i && $stable(in_pkt_i));

endmodule

`default_nettype wire

//--- rtl/fetch_stage.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_stage import core_pipe_pkg::*; #(
	parameter xlen_t RESET_PC = '0
) (
	input  wire        clock,
	input  wire        rst_n_i,
	output logic       ibus_req_valid_o,
	input  wire        ibus_req_ready_i,
	output xlen_t      ibus_addr_o,
	input  wire        ibus_resp_valid_i,
	input  xlen_t      ibus_resp_data_i,
	output logic       out_valid_o,
	input  wire        out_allowin_i,
	output fetch_pkt_t out_pkt_o
);

	logic       run_q;
	logic       wait_q;
	logic       buf_valid_q;
	xlen_t      pc_q;
	xlen_t      pend_pc_q;
	fetch_pkt_t buf_q;
	logic       drain;
	logic       req_fire;
	logic       resp_take;

	// decode takes the buffered instruction this cycle
	assign drain     = buf_valid_q && out_allowin_i;
	assign req_fire  = ibus_req_valid_o && ibus_req_ready_i;
	assign resp_take = wait_q && ibus_resp_valid_i;

	// one outstanding request, only when the buffer frees up
	assign ibus_req_valid_o = run_q && !wait_q && (!buf_valid_q || drain);
	assign ibus_addr_o      = pc_q;
	assign out_valid_o      = buf_valid_q;
	assign out_pkt_o        = buf_q;

	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			run_q       <= 1'b0;
			wait_q      <= 1'b0;
			buf_valid_q <= 1'b0;
			pc_q        <= RESET_PC;
		end else begin
			run_q <= 1'b1;
			if (req_fire) begin
				wait_q <= 1'b1;
				pc_q   <= pc_q + 32'd4;
			end else if (resp_take) begin
				wait_q <= 1'b0;
			end
			// buffer is always empty when a response lands
			if (resp_take) begin
				buf_valid_q <= 1'b1;
			end else if (drain) begin
				buf_valid_q <= 1'b0;
			end
		end
	end

	// pc of the request in flight, then the fetched pair
	always_ff @(posedge clock) begin
		if (req_fire) begin
			pend_pc_q <= pc_q;
		end
		if (resp_take) begin
			buf_q.pc    <= pend_pc_q;
			buf_q.instr <= ibus_resp_data_i;
		end
	end

	a_ibus_hold: assert property (@(posedge clock) disable iff (!rst_n_i)
		ibus_req_valid_o && !ibus_req_ready_i |=> ibus_req_valid_o && $stable(ibus_addr_o));

endmodule

`default_nettype wire

//--- rtl/decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module decode_stage import rv_isa_pkg::*, core_pipe_pkg::*; (
	input  wire          clock,
	input  wire          rst_n_i,
	input  wire          in_valid_i,
	output logic         in_allowin_o,
	input  fetch_pkt_t   in_pkt_i,
	output logic         out_valid_o,
	input  wire          out_allowin_i,
	output issue_pkt_t   out_pkt_o,
	output reg_idx_t     rf_raddr1_o,
	output reg_idx_t     rf_raddr2_o,
	input  xlen_t        rf_rdata1_i,
	input  xlen_t        rf_rdata2_i,
	bypass_if.sink       byp
);

	xlen_t    instr;
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	reg_idx_t rd;
	reg_idx_t rs1;
	reg_idx_t rs2;
	xlen_t    imm_i;
	xlen_t    imm_s;
	xlen_t    imm_u;
	xlen_t    rs1_val;
	xlen_t    rs2_val;
	logic     use_rs1;
	logic     use_rs2;
	logic     stall;

	// producer in flight that cannot supply a value yet
	function automatic logic src_busy(input reg_idx_t idx);
		logic ex_hit;
		logic ls_hit;
		ex_hit = byp.ex_valid && byp.ex_wen && (byp.ex_rd == idx);
		ls_hit = byp.ls_valid && byp.ls_wen && (byp.ls_rd == idx);
		return (idx != '0) && ((ex_hit && byp.ex_is_load) || (ls_hit && !byp.ls_data_ok));
	endfunction

	// youngest producer wins, x0 reads as zero
	function automatic xlen_t src_value(input reg_idx_t idx, input xlen_t rf_val);
		if (idx == '0)
			return '0;
		if (byp.ex_valid && byp.ex_wen && (byp.ex_rd == idx))
			return byp.ex_result;
		if (byp.ls_valid && byp.ls_wen && (byp.ls_rd == idx))
			return byp.ls_data;
		return rf_val;
	endfunction

	assign instr  = in_pkt_i.instr;
	assign opcode = instr[OPC_MSB:OPC_LSB];
	assign funct3 = instr[F3_MSB:F3_LSB];
	assign funct7 = instr[F7_MSB:F7_LSB];
	assign rd     = instr[RD_MSB:RD_LSB];
	assign rs1    = instr[RS1_MSB:RS1_LSB];
	assign rs2    = instr[RS2_MSB:RS2_LSB];

	// immediates, all sign extended from bit 31
	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_u = {instr[31:12], 12'b0};

	assign rf_raddr1_o = rs1;
	assign rf_raddr2_o = rs2;
	assign rs1_val     = src_value(rs1, rf_rdata1_i);
	assign rs2_val     = src_value(rs2, rf_rdata2_i);

	always_comb begin
		// unknown encodings fall through as a nop
		out_pkt_o            = '0;
		out_pkt_o.alu_op     = ALU_ADD;
		out_pkt_o.rd         = rd;
		out_pkt_o.op_a       = rs1_val;
		out_pkt_o.store_data = rs2_val;
		use_rs1              = 1'b0;
		use_rs2              = 1'b0;
		case (opcode)
			OPC_LUI: begin
				out_pkt_o.alu_op = ALU_PASS_B;
				out_pkt_o.op_b   = imm_u;
				out_pkt_o.wen    = 1'b1;
			end
			OPC_OP_IMM: begin
				out_pkt_o.op_b = imm_i;
				use_rs1        = 1'b1;
				out_pkt_o.wen  = (funct3 == F3_ADD) || (funct3 == F3_AND) ||
					(funct3 == F3_OR) || (funct3 == F3_XOR);
				if (funct3 == F3_AND)
					out_pkt_o.alu_op = ALU_AND;
				else if (funct3 == F3_OR)
					out_pkt_o.alu_op = ALU_OR;
				else if (funct3 == F3_XOR)
					out_pkt_o.alu_op = ALU_XOR;
			end
			OPC_OP: begin
				out_pkt_o.op_b = rs2_val;
				use_rs1        = 1'b1;
				use_rs2        = 1'b1;
				if (funct7 == F7_SUB && funct3 == F3_ADD) begin
					out_pkt_o.alu_op = ALU_SUB;
					out_pkt_o.wen    = 1'b1;
				end else if (funct7 == F7_BASE) begin
					out_pkt_o.wen = (funct3 == F3_ADD) || (funct3 == F3_AND) ||
						(funct3 == F3_OR) || (funct3 == F3_XOR);
					if (funct3 == F3_AND)
						out_pkt_o.alu_op = ALU_AND;
					else if (funct3 == F3_OR)
						out_pkt_o.alu_op = ALU_OR;
					else if (funct3 == F3_XOR)
						out_pkt_o.alu_op = ALU_XOR;
				end
			end
			OPC_LOAD: begin
				// lw only, address = rs1 + imm
				out_pkt_o.op_b    = imm_i;
				use_rs1           = (funct3 == F3_WORD);
				out_pkt_o.wen     = (funct3 == F3_WORD);
				out_pkt_o.is_load = (funct3 == F3_WORD);
			end
			OPC_STORE: begin
				out_pkt_o.op_b     = imm_s;
				use_rs1            = (funct3 == F3_WORD);
				use_rs2            = (funct3 == F3_WORD);
				out_pkt_o.is_store = (funct3 == F3_WORD);
			end
			default: begin
			end
		endcase
		// x0 destination never writes
		if (rd == '0)
			out_pkt_o.wen = 1'b0;
	end

	// load-use interlock
	assign stall = in_valid_i && ((use_rs1 && src_busy(rs1)) || (use_rs2 && src_busy(rs2)));

	assign out_valid_o  = in_valid_i && !stall;
	assign in_allowin_o = !stall && out_allowin_i;

	// fetch keeps the stalled instruction in place
	a_in_hold: assert property (@(posedge clock) disable iff (!rst_n_i)
		in_valid_i && !in_allowin_o |=> in_valid_i && $stable(in_pkt_i));

endmodule

`default_nettype wire

//--- rtl/regfile.sv
`timescale 1ns/10ps
`default_nettype none

module regfile import core_pipe_pkg::*; (
	input  wire      clock,
	input  wire      rst_n_i,
	input  reg_idx_t raddr1_i,
	input  reg_idx_t raddr2_i,
	output xlen_t    rdata1_o,
	output xlen_t    rdata2_o,
	input  wire      we_i,
	input  reg_idx_t waddr_i,
	input  xlen_t    wdata_i
);

	// x1..x31, x0 has no storage
	xlen_t regs [1:31];

	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (we_i && (waddr_i != '0)) begin
			regs[waddr_i] <= wdata_i;
		end
	end

	// combinational read ports
	assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
	assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

`default_nettype wire

//--- rtl/execute_stage.sv
`timescale 1ns/10ps
`default_nettype none

module execute_stage import rv_isa_pkg::*, core_pipe_pkg::*; (
	input  wire        in_valid_i,
	output logic       in_allowin_o,
	input  issue_pkt_t in_pkt_i,
	output logic       out_valid_o,
	input  wire        out_allowin_i,
	output mem_pkt_t   out_pkt_o,
	bypass_if.ex_src   byp
);

	xlen_t alu_res;

	always_comb begin
		case (in_pkt_i.alu_op)
			ALU_ADD:    alu_res = in_pkt_i.op_a + in_pkt_i.op_b;
			ALU_SUB:    alu_res = in_pkt_i.op_a - in_pkt_i.op_b;
			ALU_AND:    alu_res = in_pkt_i.op_a & in_pkt_i.op_b;
			ALU_OR:     alu_res = in_pkt_i.op_a | in_pkt_i.op_b;
			ALU_XOR:    alu_res = in_pkt_i.op_a ^ in_pkt_i.op_b;
			ALU_PASS_B: alu_res = in_pkt_i.op_b;
			default:    alu_res = in_pkt_i.op_b;
		endcase
	end

	// single cycle stage, ready whenever lsu side takes it
	assign out_valid_o  = in_valid_i;
	assign in_allowin_o = out_allowin_i;

	// memory ops carry the address in result
	assign out_pkt_o.result     = alu_res;
	assign out_pkt_o.rd         = in_pkt_i.rd;
	assign out_pkt_o.wen        = in_pkt_i.wen;
	assign out_pkt_o.is_load    = in_pkt_i.is_load;
	assign out_pkt_o.is_store   = in_pkt_i.is_store;
	assign out_pkt_o.store_data = in_pkt_i.store_data;

	// result is only usable by decode when not a load
	assign byp.ex_valid   = in_valid_i;
	assign byp.ex_wen     = in_pkt_i.wen;
	assign byp.ex_rd      = in_pkt_i.rd;
	assign byp.ex_result  = alu_res;
	assign byp.ex_is_load = in_pkt_i.is_load;

endmodule

`default_nettype wire

//--- rtl/lsu_stage.sv
`timescale 1ns/10ps
`default_nettype none

module lsu_stage import core_pipe_pkg::*; (
	input  wire      clock,
	input  wire      rst_n_i,
	input  wire      in_valid_i,
	output logic     in_allowin_o,
	input  mem_pkt_t in_pkt_i,
	output logic     dbus_req_valid_o,
	input  wire      dbus_req_ready_i,
	output logic     dbus_we_o,
	output xlen_t    dbus_addr_o,
	output xlen_t    dbus_wdata_o,
	input  wire      dbus_resp_valid_i,
	input  xlen_t    dbus_resp_data_i,
	output logic     rf_we_o,
	output reg_idx_t rf_waddr_o,
	output xlen_t    rf_wdata_o,
	bypass_if.ls_src byp
);

	typedef enum logic [1:0] {
		LS_IDLE,
		LS_REQ,
		LS_WAIT
	} ls_state_e;

	ls_state_e state_q;
	ls_state_e state_d;
	logic      mem_op;
	logic      resp_hit;
	logic      done;
	xlen_t     wb_data;

	assign mem_op   = in_pkt_i.is_load || in_pkt_i.is_store;
	assign resp_hit = (state_q == LS_WAIT) && dbus_resp_valid_i;

	// alu ops retire on arrival, memory ops on their response
	assign done = in_valid_i && (mem_op ? resp_hit : (state_q == LS_IDLE));

	always_comb begin
		state_d = state_q;
		case (state_q)
			LS_IDLE: if (in_valid_i && mem_op) state_d = LS_REQ;
			LS_REQ:  if (dbus_req_ready_i) state_d = LS_WAIT;
			LS_WAIT: if (dbus_resp_valid_i) state_d = LS_IDLE;
			default: state_d = LS_IDLE;
		endcase
	end

	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i)
			state_q <= LS_IDLE;
		else
			state_q <= state_d;
	end

	// request fields come straight from the held stage register
	assign dbus_req_valid_o = (state_q == LS_REQ);
	assign dbus_we_o        = in_pkt_i.is_store;
	assign dbus_addr_o      = in_pkt_i.result;
	assign dbus_wdata_o     = in_pkt_i.store_data;

	assign in_allowin_o = !in_valid_i || done;
	assign wb_data      = in_pkt_i.is_load ? dbus_resp_data_i : in_pkt_i.result;

	// write-back on the retiring edge
	assign rf_we_o    = done && in_pkt_i.wen;
	assign rf_waddr_o = in_pkt_i.rd;
	assign rf_wdata_o = wb_data;

	// load data is only good in its response cycle
	assign byp.ls_valid   = in_valid_i;
	assign byp.ls_wen     = in_pkt_i.wen;
	assign byp.ls_rd      = in_pkt_i.rd;
	assign byp.ls_data    = wb_data;
	assign byp.ls_data_ok = !in_pkt_i.is_load || resp_hit;

	a_dbus_hold: assert property (@(posedge clock) disable iff (!rst_n_i)
		dbus_req_valid_o && !dbus_req_ready_i |=> dbus_req_valid_o &&
		$stable({dbus_we_o, dbus_addr_o, dbus_wdata_o}));

endmodule

`default_nettype wire

//--- rtl/rv_core_top.sv
`timescale 1ns/10ps
`default_nettype none

module rv_core_top import core_pipe_pkg::*; #(
	parameter xlen_t RESET_PC = '0
) (
	input  wire   clock,
	input  wire   rst_n_i,
	output logic  ibus_req_valid_o,
	input  wire   ibus_req_ready_i,
	output xlen_t ibus_addr_o,
	input  wire   ibus_resp_valid_i,
	input  xlen_t ibus_resp_data_i,
	output logic  dbus_req_valid_o,
	input  wire   dbus_req_ready_i,
	output logic  dbus_we_o,
	output xlen_t dbus_addr_o,
	output xlen_t dbus_wdata_o,
	input  wire   dbus_resp_valid_i,
	input  xlen_t dbus_resp_data_i
);

	// fetch buffer to decode
	logic       fs_valid;
	logic       ds_allowin;
	fetch_pkt_t fs_pkt;

	// decode to id/ex register
	logic       ds_valid;
	logic       idex_allowin;
	issue_pkt_t ds_pkt;

	// id/ex register to execute
	logic       idex_valid;
	logic       es_allowin;
	issue_pkt_t idex_pkt;

	// execute to ex/mem register
	logic       es_valid;
	logic       exmem_allowin;
	mem_pkt_t   es_pkt;

	// ex/mem register to lsu
	logic       exmem_valid;
	logic       ls_allowin;
	mem_pkt_t   exmem_pkt;

	// register file ports
	reg_idx_t   rf_raddr1;
	reg_idx_t   rf_raddr2;
	xlen_t      rf_rdata1;
	xlen_t      rf_rdata2;
	logic       rf_we;
	reg_idx_t   rf_waddr;
	xlen_t      rf_wdata;

	bypass_if u_byp ();

	fetch_stage #(
		.RESET_PC (RESET_PC)
	) u_fetch (
		.clock             (clock),
		.rst_n_i           (rst_n_i),
		.ibus_req_valid_o  (ibus_req_valid_o),
		.ibus_req_ready_i  (ibus_req_ready_i),
		.ibus_addr_o       (ibus_addr_o),
		.ibus_resp_valid_i (ibus_resp_valid_i),
		.ibus_resp_data_i  (ibus_resp_data_i),
		.out_valid_o       (fs_valid),
		.out_allowin_i     (ds_allowin),
		.out_pkt_o         (fs_pkt)
	);

	decode_stage u_decode (
		.clock         (clock),
		.rst_n_i       (rst_n_i),
		.in_valid_i    (fs_valid),
		.in_allowin_o  (ds_allowin),
		.in_pkt_i      (fs_pkt),
		.out_valid_o   (ds_valid),
		.out_allowin_i (idex_allowin),
		.out_pkt_o     (ds_pkt),
		.rf_raddr1_o   (rf_raddr1),
		.rf_raddr2_o   (rf_raddr2),
		.rf_rdata1_i   (rf_rdata1),
		.rf_rdata2_i   (rf_rdata2),
		.byp           (u_byp.sink)
	);

	regfile u_regfile (
		.clock    (clock),
		.rst_n_i  (rst_n_i),
		.raddr1_i (rf_raddr1),
		.raddr2_i (rf_raddr2),
		.rdata1_o (rf_rdata1),
		.rdata2_o (rf_rdata2),
		.we_i     (rf_we),
		.waddr_i  (rf_waddr),
		.wdata_i  (rf_wdata)
	);

	stage_reg #(
		.PAYLOAD_T (issue_pkt_t)
	) u_id_ex (
		.clock         (clock),
		.rst_n_i       (rst_n_i),
		.in_valid_i    (ds_valid),
		.in_allowin_o  (idex_allowin),
		.in_pkt_i      (ds_pkt),
		.out_valid_o   (idex_valid),
		.out_allowin_i (es_allowin),
		.out_pkt_o     (idex_pkt)
	);

	execute_stage u_execute (
		.in_valid_i    (idex_valid),
		.in_allowin_o  (es_allowin),
		.in_pkt_i      (idex_pkt),
		.out_valid_o   (es_valid),
		.out_allowin_i (exmem_allowin),
		.out_pkt_o     (es_pkt),
		.byp           (u_byp.ex_src)
	);

	stage_reg #(
		.PAYLOAD_T (mem_pkt_t)
	) u_ex_mem (
		.clock         (clock),
		.rst_n_i       (rst_n_i),
		.in_valid_i    (es_valid),
		.in_allowin_o  (exmem_allowin),
		.in_pkt_i      (es_pkt),
		.out_valid_o   (exmem_valid),
		.out_allowin_i (ls_allowin),
		.out_pkt_o     (exmem_pkt)
	);

	// lsu also does write-back
	lsu_stage u_lsu (
		.clock             (clock),
		.rst_n_i           (rst_n_i),
		.in_valid_i        (exmem_valid),
		.in_allowin_o      (ls_allowin),
		.in_pkt_i          (exmem_pkt),
		.dbus_req_valid_o  (dbus_req_valid_o),
		.dbus_req_ready_i  (dbus_req_ready_i),
		.dbus_we_o         (dbus_we_o),
		.dbus_addr_o       (dbus_addr_o),
		.dbus_wdata_o      (dbus_wdata_o),
		.dbus_resp_valid_i (dbus_resp_valid_i),
		.dbus_resp_data_i  (dbus_resp_data_i),
		.rf_we_o           (rf_we),
		.rf_waddr_o        (rf_waddr),
		.rf_wdata_o        (rf_wdata),
		.byp               (u_byp.ls_src)
	);

endmodule

`default_nettype wire

//--- sim/tb_checker.sv
`timescale 1ns/10ps
`default_nettype none

module tb_checker #(
	parameter int          N_INSTR  = 200,
	parameter logic [31:0] RESET_PC = 32'h0000_0100
) (
	input  wire         clock,
	input  wire         rst_n_i,
	input  wire         ibus_req_valid_i,
	input  wire         ibus_req_ready_i,
	input  wire  [31:0] ibus_addr_i,
	input  wire         dbus_req_valid_i,
	input  wire         dbus_req_ready_i,
	input  wire         dbus_we_i,
	input  wire  [31:0] dbus_addr_i,
	input  wire  [31:0] dbus_wdata_i,
	output logic        done_o,
	output int          value_errs_o,
	output int          proto_errs_o
);

	localparam int N_PROG = N_INSTR + 7;
	// data window, 64 words at 0x400
	localparam logic [11:0] WIN_BASE = 12'h400;

	// opcodes straight from the base isa
	localparam logic [6:0] OP_LUI   = 7'b0110111;
	localparam logic [6:0] OP_IMM   = 7'b0010011;
	localparam logic [6:0] OP_REG   = 7'b0110011;
	localparam logic [6:0] OP_LOAD  = 7'b0000011;
	localparam logic [6:0] OP_STORE = 7'b0100011;

	logic [31:0] prog [0:N_PROG-1];
	logic [31:0] init_mem [0:63];
	logic [31:0] model_mem [0:63];
	logic [31:0] model_reg [0:7];
	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];
	int          exp_total;
	int          seen;
	logic        gen_done;

	// bus monitor state
	logic        i_wait;
	logic [31:0] i_addr_q;
	logic [31:0] exp_pc;
	logic        d_wait;
	logic [64:0] d_req_q;

	// initial data contents, a function of the full byte address
	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		return {addr[15:0], addr[31:16]} ^ (addr * 32'h9e37_79b1);
	endfunction

	function automatic logic [31:0] sext12(input logic [11:0] imm);
		return {{20{imm[11]}}, imm};
	endfunction

	// word store, base is always x0
	task automatic add_store(input int pos, input logic [4:0] rs2, input logic [5:0] k);
		logic [11:0] off;
		off = WIN_BASE | {4'b0, k, 2'b00};
		prog[pos] = {off[11:5], rs2, 5'd0, 3'b010, off[4:0], OP_STORE};
		model_mem[k] = model_reg[rs2];
		exp_addr.push_back({20'b0, off});
		exp_data.push_back(model_reg[rs2]);
	endtask

	// random program plus the isa model run ahead of the dut
	task automatic gen_program();
		int          kind;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [11:0] imm;
		logic [19:0] uimm;
		logic [5:0]  k;
		logic [31:0] a;
		logic [31:0] b;
		logic [11:0] off;
		for (int i = 0; i < 64; i++) begin
			init_mem[i] = fill_word(32'h400 + 32'(i * 4));
			model_mem[i] = init_mem[i];
		end
		for (int r = 0; r < 8; r++)
			model_reg[r] = '0;
		for (int n = 0; n < N_INSTR; n++) begin
			kind = int'($urandom_range(11, 0));
			rd   = 5'($urandom_range(7, 1));
			rs1  = 5'($urandom_range(7, 0));
			rs2  = 5'($urandom_range(7, 0));
			imm  = 12'($urandom);
			uimm = 20'($urandom);
			k    = 6'($urandom_range(63, 0));
			a    = model_reg[rs1];
			b    = model_reg[rs2];
			case (kind)
				0: begin
					prog[n] = {uimm, rd, OP_LUI};
					model_reg[rd] = {uimm, 12'b0};
				end
				1: begin
					prog[n] = {imm, rs1, 3'b000, rd, OP_IMM};
					model_reg[rd] = a + sext12(imm);
				end
				2: begin
					prog[n] = {imm, rs1, 3'b111, rd, OP_IMM};
					model_reg[rd] = a & sext12(imm);
				end
				3: begin
					prog[n] = {imm, rs1, 3'b110, rd, OP_IMM};
					model_reg[rd] = a | sext12(imm);
				end
				4: begin
					prog[n] = {imm, rs1, 3'b100, rd, OP_IMM};
					model_reg[rd] = a ^ sext12(imm);
				end
				5: begin
					prog[n] = {7'b0000000, rs2, rs1, 3'b000, rd, OP_REG};
					model_reg[rd] = a + b;
				end
				6: begin
					prog[n] = {7'b0100000, rs2, rs1, 3'b000, rd, OP_REG};
					model_reg[rd] = a - b;
				end
				7: begin
					prog[n] = {7'b0000000, rs2, rs1, 3'b111, rd, OP_REG};
					model_reg[rd] = a & b;
				end
				8: begin
					prog[n] = {7'b0000000, rs2, rs1, 3'b110, rd, OP_REG};
					model_reg[rd] = a | b;
				end
				9: begin
					prog[n] = {7'b0000000, rs2, rs1, 3'b100, rd, OP_REG};
					model_reg[rd] = a ^ b;
				end
				10: begin
					off = WIN_BASE | {4'b0, k, 2'b00};
					prog[n] = {off, 5'd0, 3'b010, rd, OP_LOAD};
					model_reg[rd] = model_mem[k];
				end
				default: begin
					add_store(n, rs2, k);
				end
			endcase
		end
		// dump x1..x7 at the top of the window
		for (int r = 1; r < 8; r++)
			add_store(N_INSTR + r - 1, 5'(r), 6'(56 + r));
		exp_total = exp_addr.size();
	endtask

	initial begin
		value_errs_o = 0;
		proto_errs_o = 0;
		seen         = 0;
		exp_total    = 0;
		gen_done     = 1'b0;
		i_wait       = 1'b0;
		d_wait       = 1'b0;
		i_addr_q     = '0;
		d_req_q      = '0;
		exp_pc       = RESET_PC;
		void'($urandom(32'h965c));
		gen_program();
		gen_done = 1'b1;
	end

	assign done_o = gen_done && (seen == exp_total);

	always @(posedge clock) begin
		if (!rst_n_i) begin
			if (dbus_req_valid_i) begin
				proto_errs_o++;
				$display("dbus request raised while reset is asserted");
			end
			i_wait = 1'b0;
			d_wait = 1'b0;
		end else begin
			// a waiting request must not move
			if (i_wait && (!ibus_req_valid_i || ibus_addr_i != i_addr_q)) begin
				proto_errs_o++;
				$display("ibus request changed or dropped before ready at %0t", $time);
			end
			if (ibus_req_valid_i && ibus_req_ready_i) begin
				if (ibus_addr_i !== exp_pc) begin
					value_errs_o++;
					$display("CHECK FAILED ibus_addr_o: got %h expected %h",
						ibus_addr_i, exp_pc);
				end
				exp_pc = exp_pc + 32'd4;
			end
			i_wait   = ibus_req_valid_i && !ibus_req_ready_i;
			i_addr_q = ibus_addr_i;

			if (d_wait && (!dbus_req_valid_i ||
				{dbus_we_i, dbus_addr_i, dbus_wdata_i} != d_req_q)) begin
				proto_errs_o++;
				$display("dbus request changed or dropped before ready at %0t", $time);
			end
			if (dbus_req_valid_i && dbus_req_ready_i) begin
				if (dbus_addr_i[31:8] != 24'h4 || dbus_addr_i[1:0] != 2'b00) begin
					proto_errs_o++;
					$display("dbus access outside the data window at %h", dbus_addr_i);
				end
				if (dbus_we_i) begin
					if (exp_addr.size() == 0) begin
						proto_errs_o++;
						$display("store seen after the last expected store");
					end else begin
						if (dbus_addr_i !== exp_addr[0]) begin
							value_errs_o++;
							$display("CHECK FAILED dbus_addr_o: got %h expected %h",
								dbus_addr_i, exp_addr[0]);
						end
						if (dbus_wdata_i !== exp_data[0]) begin
							value_errs_o++;
							$display("CHECK FAILED dbus_wdata_o: got %h expected %h",
								dbus_wdata_i, exp_data[0]);
						end
						void'(exp_addr.pop_front());
						void'(exp_data.pop_front());
						seen++;
					end
				end
			end
			d_wait  = dbus_req_valid_i && !dbus_req_ready_i;
			d_req_q = {dbus_we_i, dbus_addr_i, dbus_wdata_i};
		end
	end

endmodule

`default_nettype wire

//--- sim/tb_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_top;

	localparam int          N_INSTR  = 200;
	localparam int          N_PROG   = N_INSTR + 7;
	localparam logic [31:0] RESET_PC = 32'h0000_0100;
	localparam int          MAX_LAT  = 4;
	localparam int          TIMEOUT  = N_INSTR * 24;
	// quiet time after the last store to catch strays
	localparam int          DRAIN    = 40;

	logic        clock;
	logic        rst_n_i;
	logic        ibus_req_valid_o;
	logic        ibus_req_ready_i;
	logic [31:0] ibus_addr_o;
	logic        ibus_resp_valid_i;
	logic [31:0] ibus_resp_data_i;
	logic        dbus_req_valid_o;
	logic        dbus_req_ready_i;
	logic        dbus_we_o;
	logic [31:0] dbus_addr_o;
	logic [31:0] dbus_wdata_o;
	logic        dbus_resp_valid_i;
	logic [31:0] dbus_resp_data_i;

	logic        chk_done;
	int          value_errs;
	int          proto_errs;
	int          cycles;
	logic        timed_out;
	logic [31:0] dmem [0:63];

	// ibus model state
	logic        i_fire;
	logic [31:0] i_addr;
	logic        i_busy;
	int          i_rdy_wait;
	int          i_resp_wait;
	logic [31:0] i_data;

	// dbus model state
	logic        d_fire;
	logic        d_we;
	logic [31:0] d_addr;
	logic [31:0] d_wdata;
	logic        d_busy;
	int          d_rdy_wait;
	int          d_resp_wait;
	logic [31:0] d_data;

	rv_core_top #(
		.RESET_PC (RESET_PC)
	) dut0 (
		.clock             (clock),
		.rst_n_i           (rst_n_i),
		.ibus_req_valid_o  (ibus_req_valid_o),
		.ibus_req_ready_i  (ibus_req_ready_i),
		.ibus_addr_o       (ibus_addr_o),
		.ibus_resp_valid_i (ibus_resp_valid_i),
		.ibus_resp_data_i  (ibus_resp_data_i),
		.dbus_req_valid_o  (dbus_req_valid_o),
		.dbus_req_ready_i  (dbus_req_ready_i),
		.dbus_we_o         (dbus_we_o),
		.dbus_addr_o       (dbus_addr_o),
		.dbus_wdata_o      (dbus_wdata_o),
		.dbus_resp_valid_i (dbus_resp_valid_i),
		.dbus_resp_data_i  (dbus_resp_data_i)
	);

	tb_checker #(
		.N_INSTR  (N_INSTR),
		.RESET_PC (RESET_PC)
	) chk0 (
		.clock            (clock),
		.rst_n_i          (rst_n_i),
		.ibus_req_valid_i (ibus_req_valid_o),
		.ibus_req_ready_i (ibus_req_ready_i),
		.ibus_addr_i      (ibus_addr_o),
		.dbus_req_valid_i (dbus_req_valid_o),
		.dbus_req_ready_i (dbus_req_ready_i),
		.dbus_we_i        (dbus_we_o),
		.dbus_addr_i      (dbus_addr_o),
		.dbus_wdata_i     (dbus_wdata_o),
		.done_o           (chk_done),
		.value_errs_o     (value_errs),
		.proto_errs_o     (proto_errs)
	);

	initial clock = 1'b0;
	always #50 clock = ~clock;

	// past the program every fetch sees a nop
	function automatic logic [31:0] fetch_word(input logic [31:0] addr);
		logic [31:0] idx;
		idx = (addr - RESET_PC) >> 2;
		if (addr >= RESET_PC && idx < 32'(N_PROG))
			return chk0.prog[idx];
		return 32'h0000_0013;
	endfunction

	// instruction memory with random ready and response delays
	always @(posedge clock) begin
		i_fire = ibus_req_valid_o && ibus_req_ready_i;
		i_addr = ibus_addr_o;
		#1;
		ibus_resp_valid_i = 1'b0;
		if (!rst_n_i) begin
			ibus_req_ready_i = 1'b0;
			i_busy           = 1'b0;
			i_rdy_wait       = int'($urandom_range(MAX_LAT, 0));
		end else if (i_fire) begin
			ibus_req_ready_i = 1'b0;
			i_busy           = 1'b1;
			i_data           = fetch_word(i_addr);
			i_resp_wait      = int'($urandom_range(MAX_LAT, 0));
			i_rdy_wait       = int'($urandom_range(MAX_LAT, 0));
		end else if (i_busy) begin
			if (i_resp_wait == 0) begin
				ibus_resp_valid_i = 1'b1;
				ibus_resp_data_i  = i_data;
				i_busy            = 1'b0;
			end else begin
				i_resp_wait--;
			end
		end else if (!ibus_req_ready_i) begin
			if (i_rdy_wait == 0)
				ibus_req_ready_i = 1'b1;
			else
				i_rdy_wait--;
		end
	end

	// data memory with the same delay scheme
	always @(posedge clock) begin
		d_fire  = dbus_req_valid_o && dbus_req_ready_i;
		d_we    = dbus_we_o;
		d_addr  = dbus_addr_o;
		d_wdata = dbus_wdata_o;
		#1;
		dbus_resp_valid_i = 1'b0;
		if (!rst_n_i) begin
			dbus_req_ready_i = 1'b0;
			d_busy           = 1'b0;
			d_rdy_wait       = int'($urandom_range(MAX_LAT, 0));
		end else if (d_fire) begin
			dbus_req_ready_i = 1'b0;
			d_busy           = 1'b1;
			d_data           = '0;
			if (d_addr[31:8] == 24'h4) begin
				if (d_we)
					dmem[d_addr[7:2]] = d_wdata;
				else
					d_data = dmem[d_addr[7:2]];
			end
			d_resp_wait = int'($urandom_range(MAX_LAT, 0));
			d_rdy_wait  = int'($urandom_range(MAX_LAT, 0));
		end else if (d_busy) begin
			if (d_resp_wait == 0) begin
				dbus_resp_valid_i = 1'b1;
				dbus_resp_data_i  = d_data;
				d_busy            = 1'b0;
			end else begin
				d_resp_wait--;
			end
		end else if (!dbus_req_ready_i) begin
			if (d_rdy_wait == 0)
				dbus_req_ready_i = 1'b1;
			else
				d_rdy_wait--;
		end
	end

	initial begin
		rst_n_i           = 1'b0;
		ibus_req_ready_i  = 1'b0;
		ibus_resp_valid_i = 1'b0;
		ibus_resp_data_i  = '0;
		dbus_req_ready_i  = 1'b0;
		dbus_resp_valid_i = 1'b0;
		dbus_resp_data_i  = '0;
		timed_out         = 1'b0;
		cycles            = 0;
		// program and data image are ready by the first edge
		@(posedge clock);
		for (int i = 0; i < 64; i++)
			dmem[i] = chk0.init_mem[i];
		repeat (7) @(posedge clock);
		#1 rst_n_i = 1'b1;
		// done is looked at mid-cycle, well away from the checker's edge
		while (!chk_done && cycles < TIMEOUT) begin
			@(negedge clock);
			cycles++;
		end
		timed_out = !chk_done;
		if (timed_out)
			$display("timeout after %0d cycles, %0d of %0d stores seen",
				cycles, chk0.seen, chk0.exp_total);
		else
			repeat (DRAIN) @(posedge clock);
		$display("errors: value %0d, protocol %0d, timeout %0d",
			value_errs, proto_errs, timed_out ? 1 : 0);
		if (!timed_out && value_errs == 0 && proto_errs == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
rtl/rv_isa_pkg.sv
rtl/core_pipe_pkg.sv
rtl/bypass_if.sv
rtl/stage_reg.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/regfile.sv
rtl/execute_stage.sv
rtl/lsu_stage.sv
rtl/rv_core_top.sv
sim/tb_checker.sv
sim/tb_top.sv

//--- run_sim.sh
#!/bin/bash
# build and run the core testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f vlog.f --top-module tb_top -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -qx '\*\* PASS \*\*' &&
exit 0 ||
exit 1
